//--- common/hostLink_config.svh
`ifndef HOSTLINK_CONFIG_SVH
`define HOSTLINK_CONFIG_SVH

// ------------------------------
// serial bit timing
// ------------------------------

// system clocks per serial bit, kept small for short simulations
`define CLKS_PER_BIT 8

// ------------------------------
// scratch memory and command framing
// ------------------------------

`define MEM_AW 8 // 256 words, host address taken modulo depth

`define CMD_BYTES 7 // opcode, 16-bit address, 32-bit payload

`endif

//--- common/hostLink_pkg.sv
`default_nettype none

package hostLink_pkg;

	// host opcodes, everything else is dropped
	typedef enum logic [7:0] {
		OP_WRITE = 8'h00,
		OP_READ  = 8'h02
	} opcode_e;

	typedef logic [31:0] word_t;

	// payload of a read command
	typedef struct packed {
		logic [15:0] rsvd;
		logic [15:0] count; // words to return
	} readArgs_t;

	// data for a write, read arguments for a read
	typedef union packed {
		word_t     data;
		readArgs_t rd;
	} payload_u;

	// seven bytes on the wire, opcode first
	typedef struct packed {
		logic [7:0]  opcode;
		logic [15:0] addr;
		payload_u    payload;
	} cmd_t;

endpackage

`default_nettype wire

//--- hw/uart/uartRx.sv
`default_nettype none

`include "hostLink_config.svh"

module uartRx (
	input  wire logic       sys_clk_p,
	input  wire logic       arstN,
	input  wire logic       rxSer,
	output logic      [7:0] rxByte,
	output logic            rxStrobe
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);

	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA  = 2'd2;
	localparam logic [1:0] S_STOP  = 2'd3;

	logic [1:0]       state;
	logic [CNT_W-1:0] clkCnt;
	logic [2:0]       bitIdx;
	logic             rxMeta;
	logic             rxSync;
	logic [7:0]       rxShift;
	logic             halfDone;
	logic             bitDone;

	assign halfDone = clkCnt == CNT_W'(`CLKS_PER_BIT / 2 - 1);
	assign bitDone  = clkCnt == CNT_W'(`CLKS_PER_BIT - 1);

	always_ff @(posedge sys_clk_p or negedge arstN) begin
		if (!arstN) begin
			rxMeta   <= 1'b1; // line idles high
			rxSync   <= 1'b1;
			state    <= S_IDLE;
			clkCnt   <= '0;
			bitIdx   <= '0;
			rxStrobe <= 1'b0;
		end else begin
			rxMeta   <= rxSer;
			rxSync   <= rxMeta;
			rxStrobe <= 1'b0;
			case (state)
				S_IDLE: begin
					clkCnt <= '0;
					if (!rxSync)
						state <= S_START;
				end
				S_START: begin
					// half a bit in, from here on every sample is mid-bit
					clkCnt <= halfDone ? '0 : clkCnt + 1'b1;
					if (halfDone) begin
						bitIdx <= '0;
						state  <= rxSync ? S_IDLE : S_DATA; // glitch, back to idle
					end
				end
				S_DATA: begin
					clkCnt <= bitDone ? '0 : clkCnt + 1'b1;
					if (bitDone) begin
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7)
							state <= S_STOP;
					end
				end
				default: begin // S_STOP
					clkCnt <= bitDone ? '0 : clkCnt + 1'b1;
					if (bitDone) begin
						rxStrobe <= rxSync; // bad stop bit, byte is lost
						state    <= S_IDLE;
					end
				end
			endcase
		end
	end

	// LSB first, so new bits enter at the top
	always_ff @(posedge sys_clk_p) begin
		if (state == S_DATA && bitDone)
			rxShift <= {rxSync, rxShift[7:1]};
	end

	assign rxByte = rxShift;

endmodule

`default_nettype wire

//--- hw/uart/uartTx.sv
`default_nettype none

`include "hostLink_config.svh"

module uartTx (
	input  wire logic       sys_clk_p,
	input  wire logic       arstN,
	input  wire logic [7:0] txByte,
	input  wire logic       txStart,
	output logic            txSer,
	output logic            txBusy
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);

	logic [9:0]       frame; // stop, data, start
	logic [CNT_W-1:0] clkCnt;
	logic [3:0]       bitCnt;
	logic             bitDone;

	assign bitDone = clkCnt == CNT_W'(`CLKS_PER_BIT - 1);

	always_ff @(posedge sys_clk_p or negedge arstN) begin
		if (!arstN) begin
			frame  <= '1;
			clkCnt <= '0;
			bitCnt <= '0;
			txBusy <= 1'b0;
		end else if (!txBusy) begin
			if (txStart) begin
				frame  <= {1'b1, txByte, 1'b0};
				clkCnt <= '0;
				bitCnt <= '0;
				txBusy <= 1'b1;
			end
		end else if (bitDone) begin
			clkCnt <= '0;
			frame  <= {1'b1, frame[9:1]}; // refill with idle level
			if (bitCnt == 4'd9)
				txBusy <= 1'b0; // stop bit fully sent
			else
				bitCnt <= bitCnt + 1'b1;
		end else begin
			clkCnt <= clkCnt + 1'b1;
		end
	end

	assign txSer = frame[0];

	// the serializer upstream must wait out the whole frame
	txStartWhileBusy: assert property (@(posedge sys_clk_p) disable iff (!arstN)
		txStart |-> !txBusy);

endmodule

`default_nettype wire

//--- hw/cmdDeframer.sv
`default_nettype none

`include "hostLink_config.svh"

module cmdDeframer
	import hostLink_pkg::*;
(
	input  wire logic       sys_clk_p,
	input  wire logic       arstN,
	input  wire logic [7:0] rxByte,
	input  wire logic       rxStrobe,
	output cmd_t            cmd,
	output logic            cmdValid
);

	localparam int CNT_W = $clog2(`CMD_BYTES);
	localparam int CMD_W = $bits(cmd_t);

	logic [CNT_W-1:0] byteCnt;
	logic             lastByte;
	cmd_t             asmReg;

	assign lastByte = byteCnt == CNT_W'(`CMD_BYTES - 1);

	// ------------------------------
	// byte counter
	// ------------------------------

	always_ff @(posedge sys_clk_p or negedge arstN) begin
		if (!arstN) begin
			byteCnt  <= '0;
			cmdValid <= 1'b0;
		end else begin
			cmdValid <= rxStrobe && lastByte; // one cycle after byte seven
			if (rxStrobe)
				byteCnt <= lastByte ? '0 : byteCnt + 1'b1;
		end
	end

	// ------------------------------
	// assembly, MSB first
	// ------------------------------

	always_ff @(posedge sys_clk_p) begin
		if (rxStrobe)
			asmReg <= {asmReg[CMD_W-9:0], rxByte};
	end

	// stable until the next byte arrives
	assign cmd = asmReg;

endmodule

`default_nettype wire

//--- hw/memEngine.sv
`default_nettype none

`include "hostLink_config.svh"

module memEngine
	import hostLink_pkg::*;
(
	input  wire logic sys_clk_p,
	input  wire logic arstN,
	input  wire cmd_t cmd,
	input  wire logic cmdValid,
	input  wire logic busy,
	output word_t     rdWord,
	output logic      wordValid,
	output logic      readBusy
);

	localparam int DEPTH = 2 ** `MEM_AW;

	word_t             mem [DEPTH];
	logic [`MEM_AW-1:0] curAddr;
	logic [15:0]       remCnt;
	logic              fetch;
	logic              isWrite;
	logic              isRead;

	assign isWrite = cmdValid && cmd.opcode == OP_WRITE;
	assign isRead  = cmdValid && cmd.opcode == OP_READ;

	// one word in flight at most, wait until the serializer has taken it
	assign fetch = readBusy && !busy && !wordValid;

	// ------------------------------
	// read sequencing
	// ------------------------------

	always_ff @(posedge sys_clk_p or negedge arstN) begin
		if (!arstN) begin
			curAddr   <= '0;
			remCnt    <= '0;
			readBusy  <= 1'b0;
			wordValid <= 1'b0;
		end else begin
			wordValid <= fetch;
			if (isRead && cmd.payload.rd.count != 16'd0) begin
				curAddr  <= cmd.addr[`MEM_AW-1:0]; // modulo depth
				remCnt   <= cmd.payload.rd.count;
				readBusy <= 1'b1;
			end else if (fetch) begin
				curAddr <= curAddr + 1'b1; // wraps at the top
				remCnt  <= remCnt - 1'b1;
				if (remCnt == 16'd1)
					readBusy <= 1'b0;
			end
		end
	end

	// ------------------------------
	// scratch memory
	// ------------------------------

	always_ff @(posedge sys_clk_p) begin
		if (isWrite)
			mem[cmd.addr[`MEM_AW-1:0]] <= cmd.payload.data;
		if (fetch)
			rdWord <= mem[curAddr]; // registered read
	end

	// the host has to drain read data before the next command
	cmdDuringRead: assert property (@(posedge sys_clk_p) disable iff (!arstN)
		cmdValid |-> !readBusy);

endmodule

`default_nettype wire

//--- hw/rspSerializer.sv
`default_nettype none

module rspSerializer
	import hostLink_pkg::*;
(
	input  wire logic       sys_clk_p,
	input  wire logic       arstN,
	input  wire word_t      rdWord,
	input  wire logic       wordValid,
	input  wire logic       txBusy,
	output logic      [7:0] txByte,
	output logic            txStart,
	output logic            busy
);

	word_t      wordReg;
	logic [1:0] byteIdx;
	logic       sendByte;

	// txBusy only rises the cycle after txStart, so skip that cycle too
	assign sendByte = busy && !txBusy && !txStart;

	always_ff @(posedge sys_clk_p or negedge arstN) begin
		if (!arstN) begin
			byteIdx <= '0;
			busy    <= 1'b0;
			txStart <= 1'b0;
		end else begin
			txStart <= sendByte;
			if (wordValid && !busy) begin
				byteIdx <= '0;
				busy    <= 1'b1;
			end else if (sendByte) begin
				byteIdx <= byteIdx + 1'b1;
				if (byteIdx == 2'd3)
					busy <= 1'b0; // last byte handed over
			end
		end
	end

	// ------------------------------
	// word latch and byte select
	// ------------------------------

	always_ff @(posedge sys_clk_p) begin
		if (wordValid && !busy)
			wordReg <= rdWord;
		if (sendByte)
			txByte <= wordReg[31 - 8 * byteIdx -: 8]; // MSB first
	end

endmodule

`default_nettype wire

//--- hw/hostLink.sv
`default_nettype none

module hostLink
	import hostLink_pkg::*;
(
	input  wire logic sys_clk_p,
	input  wire logic arstN,
	input  wire logic rxSer,
	output logic      txSer
);

	logic [7:0] rxByte;
	logic       rxStrobe;
	cmd_t       cmd;
	logic       cmdValid;
	word_t      rdWord;
	logic       wordValid;
	logic       serBusy;
	logic [7:0] txByte;
	logic       txStart;
	logic       txBusy;

	// ------------------------------
	// receive path
	// ------------------------------

	uartRx rx_i (
		.sys_clk_p (sys_clk_p),
		.arstN     (arstN),
		.rxSer     (rxSer),
		.rxByte    (rxByte),
		.rxStrobe  (rxStrobe)
	);

	cmdDeframer deframer_i (
		.sys_clk_p (sys_clk_p),
		.arstN     (arstN),
		.rxByte    (rxByte),
		.rxStrobe  (rxStrobe),
		.cmd       (cmd),
		.cmdValid  (cmdValid)
	);

	memEngine engine_i (
		.sys_clk_p (sys_clk_p),
		.arstN     (arstN),
		.cmd       (cmd),
		.cmdValid  (cmdValid),
		.busy      (serBusy),
		.rdWord    (rdWord),
		.wordValid (wordValid),
		.readBusy  () // status only, the link needs no more
	);

	// ------------------------------
	// transmit path
	// ------------------------------

	rspSerializer serializer_i (
		.sys_clk_p (sys_clk_p),
		.arstN     (arstN),
		.rdWord    (rdWord),
		.wordValid (wordValid),
		.txBusy    (txBusy),
		.txByte    (txByte),
		.txStart   (txStart),
		.busy      (serBusy)
	);

	uartTx tx_i (
		.sys_clk_p (sys_clk_p),
		.arstN     (arstN),
		.txByte    (txByte),
		.txStart   (txStart),
		.txSer     (txSer),
		.txBusy    (txBusy)
	);

endmodule

`default_nettype wire

//--- dv/hostLinkTb.sv
`default_nettype none

`include "hostLink_config.svh"

module hostLinkTb
	import hostLink_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEPTH      = 2 ** `MEM_AW;
	localparam int RSP_WAIT   = 2000; // cycles allowed until a start bit
	localparam int QUIET_WAIT = `CMD_BYTES * 10 * `CLKS_PER_BIT + 200;

	logic  sys_clk_p;
	logic  arstN;
	logic  rxSer;
	logic  txSer;
	word_t model [DEPTH]; // expected memory contents
	int    checks;
	int    errors;
	int    testErrors;

	hostLink dut_i (
		.sys_clk_p (sys_clk_p),
		.arstN     (arstN),
		.rxSer     (rxSer),
		.txSer     (txSer)
	);

	initial begin
		sys_clk_p = 1'b0;
		forever #10 sys_clk_p = ~sys_clk_p;
	end

	// ------------------------------
	// serial host model
	// ------------------------------

	task automatic sendByte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0}; // stop, data, start
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk_p);
			rxSer <= frame[0];
			frame = frame >> 1;
			repeat (`CLKS_PER_BIT - 1) @(posedge sys_clk_p);
		end
	endtask

	task automatic recvByte(output logic [7:0] b, output bit ok);
		int waited;
		waited = 0;
		b = '0;
		ok = 1'b1;
		do begin
			@(negedge sys_clk_p);
			waited++;
		end while (txSer !== 1'b0 && waited < RSP_WAIT);
		if (txSer !== 1'b0) begin
			$display("no start bit on txSer within %0d cycles", RSP_WAIT);
			testErrors++;
			ok = 1'b0;
		end else begin
			repeat (`CLKS_PER_BIT / 2) @(negedge sys_clk_p); // middle of start bit
			for (int i = 0; i < 8; i++) begin
				repeat (`CLKS_PER_BIT) @(negedge sys_clk_p);
				b = {txSer, b[7:1]}; // LSB first
			end
			repeat (`CLKS_PER_BIT) @(negedge sys_clk_p);
			if (txSer !== 1'b1) begin
				$display("stop bit on txSer was not high at %0t", $time);
				testErrors++;
			end
		end
	endtask

	task automatic recvWord(output word_t w, output bit ok);
		logic [7:0] b;
		w = '0;
		ok = 1'b1;
		for (int i = 0; i < 4 && ok; i++) begin
			recvByte(b, ok);
			w = {w[23:0], b}; // first byte is the MSB
		end
	endtask

	task automatic sendCmd(input logic [7:0] op, input logic [15:0] addr, input payload_u p);
		cmd_t c;
		c.opcode  = op;
		c.addr    = addr;
		c.payload = p;
		for (int i = 0; i < `CMD_BYTES; i++) begin
			sendByte(c[$bits(cmd_t)-1 -: 8]);
			c = c << 8;
		end
	endtask

	// ------------------------------
	// compare tasks
	// ------------------------------

	task automatic checkWord(input word_t got, input word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("FAILED @%0t: %s returned %08h, expected %08h", $time, what, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkSilent(input int window, input string what);
		bit seen;
		seen = 1'b0;
		checks++;
		for (int i = 0; i < window; i++) begin
			@(negedge sys_clk_p);
			if (txSer !== 1'b1)
				seen = 1'b1;
		end
		if (seen) begin
			$display("%s: a response appeared on txSer where none was expected", what);
			testErrors++;
		end
	endtask

	// ------------------------------
	// command helpers
	// ------------------------------

	task automatic writeWord(input logic [15:0] addr, input word_t data);
		payload_u p;
		p.data = data;
		sendCmd(OP_WRITE, addr, p);
		model[addr[`MEM_AW-1:0]] = data; // address taken modulo depth
	endtask

	task automatic readCheck(input logic [15:0] addr, input int count);
		payload_u           p;
		word_t              got;
		logic [`MEM_AW-1:0] a;
		bit                 ok;
		p.rd.rsvd  = '0;
		p.rd.count = 16'(count);
		a = addr[`MEM_AW-1:0];
		ok = 1'b1;
		fork
			sendCmd(OP_READ, addr, p);
			begin
				for (int i = 0; i < count && ok; i++) begin
					recvWord(got, ok);
					if (ok)
						checkWord(got, model[a], $sformatf("word %0d of read at %04h", i, addr));
					a = a + 1'b1; // reads wrap around the memory
				end
			end
		join
	endtask

	task automatic reportTest(input string name);
		if (testErrors == 0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, testErrors);
		errors += testErrors;
		testErrors = 0;
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------

	task automatic writeReadBack();
		logic [15:0] addr;
		addr = 16'($urandom); // upper bits exercise the modulo
		writeWord(addr, $urandom);
		readCheck(addr, 1);
		reportTest("single write and read back");
	endtask

	task automatic multiWordRead();
		for (int i = 0; i < 3; i++)
			writeWord(16'(16'h0040 + i), $urandom);
		readCheck(16'h0040, 3);
		reportTest("multi-word read");
	endtask

	task automatic addressWrap();
		writeWord(16'(DEPTH - 1), $urandom);
		writeWord(16'h0000, $urandom);
		readCheck(16'(DEPTH - 1), 2);
		reportTest("address wrap");
	endtask

	task automatic unknownOpcode();
		payload_u p;
		p.data = $urandom;
		fork
			sendCmd(8'h55, 16'h0041, p);
			checkSilent(QUIET_WAIT, "unknown opcode");
		join
		readCheck(16'h0041, 1); // earlier data untouched
		reportTest("unknown opcode");
	endtask

	task automatic zeroCountOverwrite();
		payload_u p;
		p.rd.rsvd  = '0;
		p.rd.count = 16'd0;
		fork
			sendCmd(OP_READ, 16'h0040, p);
			checkSilent(QUIET_WAIT, "zero-count read");
		join
		writeWord(16'h0040, $urandom);
		readCheck(16'h0040, 1);
		reportTest("zero-count read and overwrite");
	endtask

	initial begin
		void'($urandom(32'h7a26));
		checks = 0;
		errors = 0;
		testErrors = 0;
		arstN <= 1'b0;
		rxSer <= 1'b1; // line idles high
		repeat (2) @(posedge sys_clk_p);
		arstN <= 1'b1;
		repeat (4) @(posedge sys_clk_p);
		writeReadBack();
		multiWordRead();
		addressWrap();
		unknownOpcode();
		zeroCountOverwrite();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/hostLink_pkg.sv
hw/uart/uartRx.sv
hw/uart/uartTx.sv
hw/cmdDeframer.sv
hw/memEngine.sv
hw/rspSerializer.sv
hw/hostLink.sv
dv/hostLinkTb.sv

//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = hostLinkTb
FILELIST = list.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)
